//--- filelist.f
+incdir+design
design/tf_pkg.sv
design/tf_stage_if.sv
design/tf_key_extend.sv
design/tf_subkey_inject.sv
design/tf_mix_stage.sv
design/threefish512_top.sv
verif/tf_checker.sv
verif/tb_threefish512.sv

//--- Makefile
# Verilator build and run of the Threefish-512 testbench

TOP := tb_threefish512

.PHONY: all lint clean

all:
	verilator --binary --timing --top-module $(TOP) -f filelist.f --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "sim passed"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f filelist.f
	verilator --lint-only -Wall --top-module threefish512_top +incdir+design \
		design/tf_pkg.sv design/tf_stage_if.sv design/tf_key_extend.sv \
		design/tf_subkey_inject.sv design/tf_mix_stage.sv design/threefish512_top.sv

clean:
	rm -rf obj_dir

//--- verif/tb_threefish512.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the pipelined Threefish-512 core. Drives directed,
// back-to-back, gapped and mid-stream reset traffic; tf_checker does
// the comparing. Run through the Makefile with Verilator.
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tf_defs.svh"

module tb_threefish512;

    // every block except the 40 lost to the mid-stream reset
    localparam int EXPECTED_RESULTS = 334;
    localparam int STIM_CYCLES = 10 + 20 + 2 + 200 + 4*100 + 2 + (`TF_LATENCY + 2)
                               + 40 + 10 + 30 + 2;
    localparam int TIMEOUT = STIM_CYCLES + `TF_LATENCY + 50;

    logic         clk;
    logic         arst_n;
    logic         in_valid;
    logic [511:0] plaintext;
    logic [511:0] key;
    logic [127:0] tweak;
    logic         out_valid;
    logic [511:0] ciphertext;

    int           chk_errors;
    int           checked;
    int           pending;
    int           tb_errors;
    int           seed;
    int           gap;
    int           cycles;
    logic [511:0] pt_fix;
    logic [511:0] key_fix;
    logic [127:0] tw_fix;

    threefish512_top i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .plaintext  (plaintext),
        .key        (key),
        .tweak      (tweak),
        .out_valid  (out_valid),
        .ciphertext (ciphertext)
    );

    tf_checker i_checker (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .plaintext  (plaintext),
        .key        (key),
        .tweak      (tweak),
        .out_valid  (out_valid),
        .ciphertext (ciphertext),
        .errors     (chk_errors),
        .checked    (checked),
        .pending    (pending)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;              // period 8
    end

    // all tasks start and end 1 unit after a rising edge
    task automatic random_block(output logic [511:0] val);
        for (int j = 0; j < 16; j++) begin
            val[32*j +: 32] = $random(seed);
        end
    endtask

    task automatic random_tweak(output logic [127:0] val);
        for (int j = 0; j < 4; j++) begin
            val[32*j +: 32] = $random(seed);
        end
    endtask

    task automatic send_block(input logic [511:0] pt, input logic [511:0] k,
                              input logic [127:0] tw);
        in_valid  = 1'b1;
        plaintext = pt;
        key       = k;
        tweak     = tw;
        @(posedge clk);
        #1;
    endtask

    task automatic send_random();
        logic [511:0] pt;
        logic [511:0] k;
        logic [127:0] tw;
        random_block(pt);
        random_block(k);
        random_tweak(tw);
        send_block(pt, k, tw);
    endtask

    task automatic idle_cycles(input int n);
        in_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_drain();
        in_valid = 1'b0;
        while (pending != 0) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic apply_reset(input int n);
        arst_n   = 1'b0;                    // async assert clears every valid at once
        in_valid = 1'b0;
        repeat (n) @(posedge clk);
        #1;
        arst_n = 1'b1;
    endtask

    // run limit
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT);
        $display("sim failed");
        $finish;
    end

    initial begin
        seed      = 32'h5450_9e7b;
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        plaintext = '0;
        key       = '0;
        tweak     = '0;
        tb_errors = 0;
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;

        idle_cycles(20);                    // nothing may come out yet

        send_block('0, '0, '0);             // corner values
        send_block('1, '1, '1);

        repeat (200) send_random();         // full rate

        repeat (100) begin                  // gapped stream
            send_random();
            gap = $unsigned($random(seed)) % 4;
            idle_cycles(gap);
        end

        // same block and key with only t1 flipped
        random_block(pt_fix);
        random_block(key_fix);
        random_tweak(tw_fix);
        send_block(pt_fix, key_fix, tw_fix);
        send_block(pt_fix, key_fix, {tw_fix[127:64], ~tw_fix[63:0]});
        wait_drain();

        repeat (40) send_random();          // still inside the pipe at reset
        apply_reset(10);
        repeat (30) send_random();
        wait_drain();
        idle_cycles(10);                    // catch late strays

        if (checked != EXPECTED_RESULTS) begin
            $display("wrong number of results: expected %0d, got %0d",
                     EXPECTED_RESULTS, checked);
            tb_errors++;
        end
        $display("%0d results checked, %0d checker errors, %0d testbench errors",
                 checked, chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/tf_checker.sv
//////////////////////////////////////////////////////////////////////
// Scoreboard for the Threefish-512 core. Sits beside the DUT, queues
// every accepted input, recomputes the ciphertext with its own model
// and checks value and latency of every output. Flushes on reset.
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tf_defs.svh"

module tf_checker (
    input  wire logic         clk,
    input  wire logic         arst_n,
    input  wire logic         in_valid,
    input  wire logic [511:0] plaintext,
    input  wire logic [511:0] key,
    input  wire logic [127:0] tweak,
    input  wire logic         out_valid,
    input  wire logic [511:0] ciphertext,
    output int                errors,
    output int                checked,
    output int                pending
);

    // Threefish-512 rotation amounts, row = round mod 8
    localparam int ROT_TBL [0:7][0:3] = '{
        '{46, 36, 19, 37}, '{33, 27, 14, 42}, '{17, 49, 36, 39}, '{44,  9, 54, 56},
        '{39, 30, 34, 24}, '{13, 50, 10, 17}, '{25, 29, 39, 43}, '{ 8, 35, 56, 22}
    };
    localparam int PERM_TBL [0:7] = '{2, 1, 4, 7, 6, 5, 0, 3};  // new lane i <- old lane

    typedef struct packed {
        logic [511:0] pt;
        logic [511:0] key;
        logic [127:0] tw;
        int           cyc;      // negedge count when accepted
    } entry_t;

    entry_t       q [$];
    entry_t       head;
    logic [511:0] expected;
    int           cycle   = 0;
    int           err_cnt = 0;
    int           chk_cnt = 0;

    assign errors  = err_cnt;
    assign checked = chk_cnt;
    assign pending = q.size();

    function automatic tf_pkg::tf_word_t rotate_left(input tf_pkg::tf_word_t x, input int r);
        return (x << r) | (x >> (`TF_WORD_W - r));
    endfunction

    // straight Threefish-512 encryption, lane 0 in the top bits
    function automatic logic [511:0] tf_encrypt(input logic [511:0] pt,
                                                input logic [511:0] key_in,
                                                input logic [127:0] tweak_in);
        tf_pkg::tf_word_t v [0:7];
        tf_pkg::tf_word_t y [0:7];
        tf_pkg::tf_word_t k [0:8];
        tf_pkg::tf_word_t t [0:2];
        logic [511:0]     res;
        int               s;
        k[8] = `TF_KEY_PARITY;
        for (int i = 0; i < 8; i++) begin
            v[i] = pt[511-64*i -: 64];
            k[i] = key_in[511-64*i -: 64];
            k[8] = k[8] ^ k[i];                 // parity word
        end
        t[0] = tweak_in[127:64];
        t[1] = tweak_in[63:0];
        t[2] = t[0] ^ t[1];
        for (int d = 0; d <= `TF_ROUNDS; d++) begin
            if (d % 4 == 0) begin               // subkey s before rounds 4s..4s+3
                s = d / 4;
                for (int i = 0; i < 8; i++) begin
                    v[i] = v[i] + k[(s + i) % 9];
                end
                v[5] = v[5] + t[s % 3];
                v[6] = v[6] + t[(s + 1) % 3];
                v[7] = v[7] + tf_pkg::tf_word_t'(s);
            end
            if (d < `TF_ROUNDS) begin
                for (int p = 0; p < 4; p++) begin
                    y[2*p]   = v[2*p] + v[2*p+1];
                    y[2*p+1] = rotate_left(v[2*p+1], ROT_TBL[d % 8][p]) ^ y[2*p];
                end
                for (int i = 0; i < 8; i++) begin
                    v[i] = y[PERM_TBL[i]];
                end
            end
        end
        for (int i = 0; i < 8; i++) begin
            res[511-64*i -: 64] = v[i];
        end
        return res;
    endfunction

    // negedge sampling, inputs and outputs both settled here
    always @(negedge clk) begin
        if (!arst_n) begin
            q.delete();                         // blocks in flight are gone
        end else begin
            // results that never came out
            while (q.size() > 0 && q[0].cyc + `TF_LATENCY < cycle) begin
                $display("missing output for the block accepted in cycle %0d", q[0].cyc);
                err_cnt++;
                void'(q.pop_front());
            end
            if (out_valid) begin
                if (q.size() == 0) begin
                    $display("unexpected output at time %0t with no block in flight", $time);
                    err_cnt++;
                end else begin
                    head     = q.pop_front();
                    expected = tf_encrypt(head.pt, head.key, head.tw);
                    if (cycle - head.cyc != `TF_LATENCY) begin
                        $display("CHECK FAILED at %0t: latency %0d, expected %0d",
                                 $time, cycle - head.cyc, `TF_LATENCY);
                        err_cnt++;
                    end
                    if (ciphertext !== expected) begin
                        $display("CHECK FAILED at %0t: wrong ciphertext for block of cycle %0d",
                                 $time, head.cyc);
                        $display("  got      %h", ciphertext);
                        $display("  expected %h", expected);
                        err_cnt++;
                    end
                    chk_cnt++;
                end
            end
            if (in_valid) begin
                q.push_back('{pt: plaintext, key: key, tw: tweak, cyc: cycle});
            end
        end
        cycle++;
    end

endmodule

`default_nettype wire

//--- design/threefish512_top.sv
//////////////////////////////////////////////////////////////////////
// Fully pipelined Threefish-512 encryption core. Takes one block, key
// and tweak per cycle with in_valid, returns the ciphertext with
// out_valid a fixed TF_LATENCY cycles later. No back-pressure.
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tf_defs.svh"

module threefish512_top (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              in_valid,
    input  logic [`TF_LANES*`TF_WORD_W-1:0]   plaintext,
    input  logic [`TF_LANES*`TF_WORD_W-1:0]   key,
    input  logic [2*`TF_WORD_W-1:0]           tweak,       // t0 in the top half
    output logic                              out_valid,
    output logic [`TF_LANES*`TF_WORD_W-1:0]   ciphertext
);

    localparam int RND_PER_GRP = `TF_ROUNDS / `TF_GROUPS;       // 4
    localparam int GRP_STAGES  = RND_PER_GRP + 1;               // inject + mixes
    localparam int N_STAGES    = 1 + GRP_STAGES * `TF_GROUPS + 1;  // 92

    tf_pkg::tf_block_u pt_blk;

    // stg[n] is the output of stage n
    tf_stage_if stg [0:N_STAGES-1] ();

    assign pt_blk.flat = plaintext;

    tf_key_extend i_key_extend (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .plaintext (pt_blk),
        .key       (key),
        .tweak     (tweak),
        .out       (stg[0])
    );

    for (genvar g = 0; g < `TF_GROUPS; g++) begin : g_grp
        // subkey g goes in ahead of rounds 4g .. 4g+3
        tf_subkey_inject #(.SUBKEY_INDEX(g)) i_inject (
            .clk    (clk),
            .arst_n (arst_n),
            .in     (stg[GRP_STAGES*g]),
            .out    (stg[GRP_STAGES*g+1])
        );

        for (genvar r = 0; r < RND_PER_GRP; r++) begin : g_rnd
            // odd groups take rotation rows 4..7
            tf_mix_stage #(.ROUND_POS(RND_PER_GRP*(g%2)+r)) i_mix (
                .clk    (clk),
                .arst_n (arst_n),
                .in     (stg[GRP_STAGES*g+1+r]),
                .out    (stg[GRP_STAGES*g+2+r])
            );
        end
    end

    // output whitening with subkey 18
    tf_subkey_inject #(.SUBKEY_INDEX(`TF_GROUPS)) i_inject_last (
        .clk    (clk),
        .arst_n (arst_n),
        .in     (stg[GRP_STAGES*`TF_GROUPS]),
        .out    (stg[N_STAGES-1])
    );

    assign out_valid  = stg[N_STAGES-1].valid;
    assign ciphertext = stg[N_STAGES-1].block.flat;

endmodule

`default_nettype wire

//--- design/tf_mix_stage.sv
//////////////////////////////////////////////////////////////////////
// One Threefish-512 round as a pipeline stage: four MIX functions on
// lane pairs, then the word permutation. ROUND_POS is the round number
// mod 8 and picks the rotation row. Key and tweak ride along untouched.
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tf_defs.svh"

module tf_mix_stage #(
    parameter int unsigned ROUND_POS = 0    // 0 .. 7
) (
    input  logic    clk,
    input  logic    arst_n,
    tf_stage_if.dst in,
    tf_stage_if.src out
);

    // Threefish-512 rotation constants, row = round mod 8, column = pair
    localparam int ROT [0:7][0:3] = '{
        '{46, 36, 19, 37},
        '{33, 27, 14, 42},
        '{17, 49, 36, 39},
        '{44,  9, 54, 56},
        '{39, 30, 34, 24},
        '{13, 50, 10, 17},
        '{25, 29, 39, 43},
        '{ 8, 35, 56, 22}
    };

    // new lane i takes old lane PERM[i]
    localparam int PERM [0:`TF_LANES-1] = '{2, 1, 4, 7, 6, 5, 0, 3};

    tf_pkg::tf_block_u mixed;
    tf_pkg::tf_block_u permuted;

    // amounts are never 0 so the right shift stays below 64
    function automatic tf_pkg::tf_word_t rotl(input tf_pkg::tf_word_t x, input int r);
        return (x << r) | (x >> (`TF_WORD_W - r));
    endfunction

    always_comb begin
        for (int p = 0; p < `TF_LANES / 2; p++) begin
            mixed.lanes[2*p]   = in.block.lanes[2*p] + in.block.lanes[2*p+1];  // y0 = x0 + x1
            mixed.lanes[2*p+1] = rotl(in.block.lanes[2*p+1], ROT[ROUND_POS][p])
                               ^ mixed.lanes[2*p];                             // y1 = rotl(x1) ^ y0
        end
    end

    always_comb begin
        for (int i = 0; i < `TF_LANES; i++) begin
            permuted.lanes[i] = mixed.lanes[PERM[i]];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        out.block <= permuted;
        out.key   <= in.key;    // pass through
        out.tweak <= in.tweak;
    end

endmodule

`default_nettype wire

//--- design/tf_subkey_inject.sv
//////////////////////////////////////////////////////////////////////
// Subkey injection stage, one per group plus the final one.
// Adds subkey SUBKEY_INDEX to the block, then rotates key and tweak
// by one word so the next injection can use the same lane wiring.
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tf_defs.svh"

module tf_subkey_inject #(
    parameter int unsigned SUBKEY_INDEX = 0     // 0 .. 18
) (
    input  logic    clk,
    input  logic    arst_n,
    tf_stage_if.dst in,
    tf_stage_if.src out
);

    tf_pkg::tf_block_u sum;        // block plus subkey
    tf_pkg::tf_key_t   key_rot;    // key word s+1 moved to lane 0
    tf_pkg::tf_tweak_t tweak_rot;  // tweak word s+1 moved to slot 0

    // incoming key is already rotated by s, so lane i sees k[(s+i) mod 9]
    always_comb begin
        for (int i = 0; i < `TF_LANES; i++) begin
            sum.lanes[i] = in.block.lanes[i] + in.key[i];
        end
        sum.lanes[5] = sum.lanes[5] + in.tweak[0];   // t[s mod 3]
        sum.lanes[6] = sum.lanes[6] + in.tweak[1];   // t[(s+1) mod 3]
        sum.lanes[7] = sum.lanes[7] + tf_pkg::tf_word_t'(SUBKEY_INDEX);
    end

    // rotate left by one word, k0 wraps to the bottom
    assign key_rot   = {in.key[1:`TF_KEY_LANES-1], in.key[0]};
    assign tweak_rot = {in.tweak[1:`TF_TWEAK_LANES-1], in.tweak[0]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        out.block <= sum;
        out.key   <= key_rot;
        out.tweak <= tweak_rot;
    end

endmodule

`default_nettype wire

//--- design/tf_key_extend.sv
//////////////////////////////////////////////////////////////////////
// Entry stage of the pipeline. Registers the plaintext and builds the
// 9-word key and 3-word tweak used by every subkey injection.
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tf_defs.svh"

module tf_key_extend (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              in_valid,
    input  tf_pkg::tf_block_u                 plaintext,
    input  logic [`TF_LANES*`TF_WORD_W-1:0]   key,
    input  logic [2*`TF_WORD_W-1:0]           tweak,
    tf_stage_if.src                           out
);

    tf_pkg::tf_block_u key_blk;    // key split into lanes
    tf_pkg::tf_word_t  key_par;    // ninth key word
    tf_pkg::tf_word_t  tweak_x;    // third tweak word

    assign key_blk.flat = key;

    // k8 = C240 ^ k0 ^ ... ^ k7
    always_comb begin
        key_par = `TF_KEY_PARITY;
        for (int i = 0; i < `TF_LANES; i++) begin
            key_par = key_par ^ key_blk.lanes[i];
        end
    end

    assign tweak_x = tweak[2*`TF_WORD_W-1:`TF_WORD_W] ^ tweak[`TF_WORD_W-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in_valid;  // empty slots travel too
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        out.block <= plaintext;
        out.key   <= {key_blk.flat, key_par};   // k0 at the top
        out.tweak <= {tweak, tweak_x};          // t0 at the top
    end

endmodule

`default_nettype wire

//--- design/tf_stage_if.sv
//////////////////////////////////////////////////////////////////////
// Link between two pipeline stages of the cipher core.
// The upstream stage drives through src, the downstream one reads dst.
//////////////////////////////////////////////////////////////////////

`default_nettype none

interface tf_stage_if;

    logic               valid;  // qualifies the rest, no stall
    tf_pkg::tf_block_u  block;  // state words being encrypted
    tf_pkg::tf_key_t    key;    // extended key, rotated per injection
    tf_pkg::tf_tweak_t  tweak;  // extended tweak, rotated per injection

    // stage that owns the registers
    modport src (
        output valid,
        output block,
        output key,
        output tweak
    );

    // stage that consumes them
    modport dst (
        input valid,
        input block,
        input key,
        input tweak
    );

endinterface

`default_nettype wire

//--- design/tf_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared Threefish-512 data types.
// Referenced by scoped name from the RTL and the checker.
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tf_defs.svh"

package tf_pkg;

    typedef logic [`TF_WORD_W-1:0] tf_word_t;   // one 64-bit lane

    // one 512-bit block, seen flat at the ports or as lanes in the rounds
    // lane 0 sits in the top 64 bits
    typedef union packed {
        logic [`TF_LANES*`TF_WORD_W-1:0] flat;
        tf_word_t [0:`TF_LANES-1]        lanes;
    } tf_block_u;

    // extended key, word 8 is the parity word
    typedef tf_word_t [0:`TF_KEY_LANES-1] tf_key_t;

    // extended tweak, word 2 = t0 ^ t1
    typedef tf_word_t [0:`TF_TWEAK_LANES-1] tf_tweak_t;

endpackage

`default_nettype wire

//--- design/tf_defs.svh
//////////////////////////////////////////////////////////////////////
// Threefish-512 core dimensions and constants.
// Included by the RTL and the testbench wherever sizes are needed.
//////////////////////////////////////////////////////////////////////

`ifndef TF_DEFS_SVH
`define TF_DEFS_SVH

// lane geometry
`define TF_WORD_W       64
`define TF_LANES        8
`define TF_KEY_LANES    9   // 8 key words plus parity word
`define TF_TWEAK_LANES  3   // 2 tweak words plus xor word

// round structure, 4 rounds per group
`define TF_ROUNDS       72
`define TF_GROUPS       18

// key schedule parity constant
`define TF_KEY_PARITY   64'h1BD1_1BDA_A9FC_1A22

// key extend + 18 x (inject + 4 mix) + final inject
`define TF_LATENCY      92

`endif
